/* bench/router_props.sv */
// Switch allocator properties for load, grant uniqueness and wormhole lock
`timescale 1ns/1ps

module router_props (
  input logic                                                 clk,
  input logic                                                 rst_n,
  input logic [router_pkg::NUM_PORTS-1:0]                     take,
  input logic [router_pkg::NUM_PORTS-1:0]                     load,
  input logic [router_pkg::NUM_PORTS-1:0]                     locked,
  input router_pkg::port_t [router_pkg::NUM_PORTS-1:0]        lock_in,
  input logic [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_PORTS-1:0] out_grant
);
  import router_pkg::*;

  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] by_input;

  // Each row lists the outputs granting one input
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        by_input[i][o] = out_grant[o][i];
      end
    end
  end

  load_needs_take: assert property (@(posedge clk) disable iff (!rst_n) (load & ~take) == '0)
    else $error("load raised on an output whose register cannot take a flit");

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
    single_grant: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(by_input[i]))
      else $error("input %0d granted by more than one output", i);
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
    lock_owner: assert property (@(posedge clk) disable iff (!rst_n)
      locked[o] |-> ((out_grant[o] & ~(NUM_PORTS'(1) << lock_in[o])) == '0))
      else $error("locked output %0d granted an input other than its owner", o);
  end

endmodule

bind switch_allocator router_props u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .take      (take),
  .load      (load),
  .locked    (locked),
  .lock_in   (lock_in),
  .out_grant (out_grant)
);

/* bench/router_stim.txt */
# flit <test> <in_port> <kind> <vc> <dest_x> <dest_y> <payload_hex> <gap>
# kind 0 head, 1 body, 2 tail, 3 single; port 0 N, 1 S, 2 E, 3 W, 4 local
# ready <out_port> <mode> <hold>: mode 0 ready, 1 random stalls, 2 low for hold cycles
# full <test> <in_port> <flits accepted before in_ready falls, 4 buffered + 1 in output>
ready 0 1 0
ready 2 1 0
flit routing 4 3 0 3 2 0a01 1
flit routing 4 3 0 0 0 0a02 0
flit routing 4 3 1 1 3 0a03 2
flit routing 4 3 0 1 0 0a04 0
flit routing 4 3 1 1 2 0a05 0
flit wormhole 0 0 0 3 1 0b01 0
flit wormhole 3 0 1 3 1 0b11 0
flit wormhole 0 1 0 3 1 0b02 0
flit wormhole 3 1 1 3 1 0b12 0
flit wormhole 0 2 0 3 1 0b03 0
flit wormhole 3 2 1 3 1 0b13 0
flit vchannels 1 0 0 0 3 0c01 0
flit vchannels 1 0 1 0 1 0c11 0
flit vchannels 1 2 0 0 3 0c02 0
flit vchannels 1 2 1 0 1 0c12 0
ready 1 2 30
flit stall 2 0 1 1 1 0d01 0
flit stall 2 1 1 1 1 0d02 0
flit stall 2 1 1 1 1 0d03 0
flit stall 2 1 1 1 1 0d04 0
flit stall 2 1 1 1 1 0d05 0
flit stall 2 2 1 1 1 0d06 0
full stall 2 5

/* bench/router_tb.sv */
// Router testbench with file-driven stimulus, scoreboard, compare tasks and watchdog
`timescale 1ns/1ps

module router_tb;
  import router_pkg::*;

  localparam coord_t MY_X    = 2'd1;
  localparam coord_t MY_Y    = 2'd2;
  localparam int     NUM_SRC = NUM_PORTS * NUM_VCS;
  localparam int     SEED    = 32'hbdb3_ab2e;

  typedef enum int {OP_FLIT, OP_READY, OP_FULL} op_e;

  // Pending flit of one source tagged with its expected output
  typedef struct packed {
    flit_t flit;
    port_t out;
    int    line;
  } exp_entry_t;

  logic                              clk;
  logic                              rst_n;
  logic  [NUM_PORTS-1:0]             in_valid;
  flit_t [NUM_PORTS-1:0]             in_flit;
  logic  [NUM_PORTS-1:0]             in_ready;
  logic  [NUM_PORTS-1:0]             out_valid;
  flit_t [NUM_PORTS-1:0]             out_flit;
  logic  [NUM_PORTS-1:0]             out_ready;
  logic  [NUM_PORTS-1:0][NUM_VCS-1:0] vc_busy;
  count_t                            packets_routed;

  // Stimulus file contents with one entry per line
  op_e        line_op [$];
  string      line_test [$];
  int         line_port [$];
  int         line_arg [$];
  int         line_hold [$];
  flit_t      line_flit [$];
  int         line_gap [$];
  int         total_flits;
  int         packets_expected;
  bit         stim_loaded;

  exp_entry_t exp_q [NUM_SRC][$];
  port_t      pkt_port [NUM_SRC];
  int         lock_src [NUM_PORTS];
  int         accepted [NUM_PORTS];
  int         blocked_at [NUM_PORTS];
  bit         was_blocked [NUM_PORTS];
  int         ready_mode [NUM_PORTS];
  int         stall_end [NUM_PORTS];
  int         cycle;
  int         cur_line;

  router_top #(
    .ROUTER_X (MY_X),
    .ROUTER_Y (MY_Y)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_flit        (in_flit),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_flit       (out_flit),
    .out_ready      (out_ready),
    .vc_busy        (vc_busy),
    .packets_routed (packets_routed)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_flit(input string test, input flit_t exp, input flit_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("Mismatch in %s: expected flit %h, actual %h", test, exp, act));
    end
  endtask

  task automatic compare_port(input string test, input port_t exp, input port_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("Mismatch in %s: expected port %0d, actual %0d", test, exp, act));
    end
  endtask

  task automatic compare_count(input string test, input count_t exp, input count_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("Mismatch in %s: expected count %0d, actual %0d", test, exp, act));
    end
  endtask

  // Leave along x first, then along y, else deliver locally
  function automatic port_t expected_port(input coord_t dx, input coord_t dy);
    if (dx != MY_X) return (dx > MY_X) ? PORT_EAST : PORT_WEST;
    if (dy != MY_Y) return (dy > MY_Y) ? PORT_NORTH : PORT_SOUTH;
    return PORT_LOCAL;
  endfunction

  function automatic flit_t make_flit(input int kind, input int vc, input int dx, input int dy,
                                      input int payload);
    flit_t f;
    f = '0;
    f[KIND_LSB +: KIND_W]       = kind_t'(kind);
    f[VC_LSB +: VC_W]           = vc_t'(vc);
    f[DX_LSB +: COORD_W]        = coord_t'(dx);
    f[DY_LSB +: COORD_W]        = coord_t'(dy);
    f[PAYLOAD_LSB +: PAYLOAD_W] = PAYLOAD_W'(payload);
    return f;
  endfunction

  task automatic load_stimulus();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    int    d;
    int    e;
    int    g;
    int    h;
    string line;
    string word;
    string test;
    fd = $fopen("bench/router_stim.txt", "r");
    if (fd == 0) stop_with_error("cannot open the stimulus file bench/router_stim.txt");
    test = "";
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != 8'h23 && $sscanf(line, "%s", word) == 1) begin
        a = 0;
        b = 0;
        c = 0;
        d = 0;
        e = 0;
        g = 0;
        h = 0;
        if (word == "ready") begin
          n = $sscanf(line, "%s %d %d %d", word, a, b, c);
          if (n != 4) stop_with_error("malformed ready line in the stimulus file");
          line_op.push_back(OP_READY);
        end else if (word == "flit") begin
          n = $sscanf(line, "%s %s %d %d %d %d %d %h %d", word, test, a, b, c, d, e, g, h);
          if (n != 9) stop_with_error("malformed flit line in the stimulus file");
          line_op.push_back(OP_FLIT);
          total_flits = total_flits + 1;
          if (b == 2 || b == 3) packets_expected = packets_expected + 1;
        end else if (word == "full") begin
          n = $sscanf(line, "%s %s %d %d", word, test, a, b);
          if (n != 4) stop_with_error("malformed full line in the stimulus file");
          line_op.push_back(OP_FULL);
        end else begin
          stop_with_error("unknown line kind in the stimulus file");
        end
        line_test.push_back(test);
        line_port.push_back(a);
        line_arg.push_back(b);
        line_hold.push_back(c);
        line_flit.push_back(make_flit(b, c, d, e, g));
        line_gap.push_back(h);
      end
    end
    $fclose(fd);
  endtask

  task automatic send_flit(input int i);
    int p;
    p = line_port[i];
    cur_line    = i;
    in_flit[p]  = line_flit[i];
    in_valid[p] = 1'b1;
    @(posedge clk);
    while (!in_ready[p]) @(posedge clk);
    @(negedge clk);
    in_valid[p] = 1'b0;
    repeat (line_gap[i]) @(negedge clk);
  endtask

  task automatic wait_drained();
    int pending;
    do begin
      @(negedge clk);
      pending = 0;
      for (int s = 0; s < NUM_SRC; s++) pending = pending + exp_q[s].size();
    end while (pending != 0);
  endtask

  function automatic int find_flit(input int s, input flit_t f);
    for (int i = 0; i < exp_q[s].size(); i++) begin
      if (exp_q[s][i].flit == f) return i;
    end
    return -1;
  endfunction

  function automatic int find_tagged(input int s, input int o);
    for (int i = 0; i < exp_q[s].size(); i++) begin
      if (exp_q[s][i].out == port_t'(o)) return i;
    end
    return -1;
  endfunction

  // A packet start picks its source; the rest must follow from that source in order
  task automatic check_output(input int o, input flit_t f);
    kind_t k;
    int    src;
    int    idx;
    int    t;
    k   = f[KIND_LSB +: KIND_W];
    src = lock_src[o];
    if (k == KIND_HEAD || k == KIND_SINGLE) begin
      src = -1;
      for (int s = 0; s < NUM_SRC; s++) begin
        idx = find_flit(s, f);
        if (src < 0 && idx >= 0) begin
          src = s;
          compare_port(line_test[exp_q[s][idx].line], exp_q[s][idx].out, port_t'(o));
        end
      end
      lock_src[o] = src;
    end
    if (src < 0) stop_with_error($sformatf("flit %h on output %0d matches no flit sent", f, o));
    t = find_tagged(src, o);
    if (t < 0) stop_with_error($sformatf("flit %h on output %0d was not expected there", f, o));
    compare_flit(line_test[exp_q[src][t].line], exp_q[src][t].flit, f);
    exp_q[src].delete(t);
    if (k == KIND_TAIL || k == KIND_SINGLE) lock_src[o] = -1;
  endtask

  // ============================================================
  // Input and output monitor
  // ============================================================
  always @(posedge clk) begin
    int         src;
    exp_entry_t e;
    if (!rst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        lock_src[p]    = -1;
        accepted[p]    = 0;
        blocked_at[p]  = -1;
        was_blocked[p] = 1'b0;
      end
      for (int s = 0; s < NUM_SRC; s++) pkt_port[s] = PORT_LOCAL;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (in_valid[p] && in_ready[p]) begin
          src = p * NUM_VCS + int'(in_flit[p][VC_LSB +: VC_W]);
          if (in_flit[p][KIND_LSB +: KIND_W] inside {KIND_HEAD, KIND_SINGLE}) begin
            pkt_port[src] = expected_port(in_flit[p][DX_LSB +: COORD_W],
                                          in_flit[p][DY_LSB +: COORD_W]);
          end
          e.flit = in_flit[p];
          e.out  = pkt_port[src];
          e.line = cur_line;
          exp_q[src].push_back(e);
          accepted[p]    = accepted[p] + 1;
          was_blocked[p] = 1'b0;
        end else if (in_valid[p] && !was_blocked[p]) begin
          was_blocked[p] = 1'b1;
          blocked_at[p]  = accepted[p];
        end
      end
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (out_valid[o] && out_ready[o]) check_output(o, out_flit[o]);
      end
    end
  end

  // Output ready stays high, stalls at random or is held low for a while
  initial begin
    void'($urandom(SEED));
    out_ready = '1;
    cycle     = 0;
    forever begin
      @(negedge clk);
      cycle = cycle + 1;
      for (int p = 0; p < NUM_PORTS; p++) begin
        case (ready_mode[p])
          1:       out_ready[p] = ($urandom % 3) != 0;
          2:       out_ready[p] = (cycle >= stall_end[p]);
          default: out_ready[p] = 1'b1;
        endcase
      end
    end
  end

  initial begin
    wait (stim_loaded);
    repeat (total_flits * 40 + 200) @(posedge clk);
    stop_with_error("watchdog expired before all flits were delivered");
  end

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    string prev_test;
    int    start_count [NUM_PORTS];
    int    p;
    rst_n    = 1'b0;
    in_valid = '0;
    in_flit  = '0;
    cur_line = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      ready_mode[i] = 0;
      stall_end[i]  = 0;
    end
    load_stimulus();
    stim_loaded = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n     = 1'b1;
    prev_test = "";
    for (int i = 0; i < line_op.size(); i++) begin
      p = line_port[i];
      // Each test starts with the router empty
      if (line_op[i] != OP_READY && line_test[i] != prev_test) begin
        wait_drained();
        prev_test = line_test[i];
        for (int q = 0; q < NUM_PORTS; q++) start_count[q] = accepted[q];
      end
      case (line_op[i])
        OP_READY: begin
          ready_mode[p] = line_arg[i];
          stall_end[p]  = cycle + line_hold[i];
        end
        OP_FULL:  compare_count(line_test[i], count_t'(line_arg[i]),
                                count_t'(blocked_at[p] - start_count[p]));
        default:  send_flit(i);
      endcase
    end
    wait_drained();
    repeat (2) @(negedge clk);
    compare_count("status", count_t'(packets_expected), packets_routed);
    compare_count("status", '0, count_t'($countones(vc_busy)));
    if (out_valid != '0) stop_with_error("a flit was left in an output register at the end");
    $display("test passed");
    $finish;
  end

endmodule

/* common/router_pkg.sv */
// Router widths, flit field layout, flit kinds, port numbers and channel states
package router_pkg;

  localparam int NUM_PORTS = 5;
  localparam int NUM_VCS   = 2;
  localparam int VC_DEPTH  = 4;
  localparam int COORD_W   = 2;
  localparam int PAYLOAD_W = 16;
  localparam int KIND_W    = 2;
  localparam int VC_W      = 1;
  localparam int PORT_W    = 3;
  localparam int COUNT_W   = 16;
  localparam int FLIT_W    = KIND_W + VC_W + 2 * COORD_W + PAYLOAD_W;

  // Field positions counted up from the payload in the low bits
  localparam int PAYLOAD_LSB = 0;
  localparam int DY_LSB      = PAYLOAD_LSB + PAYLOAD_W;
  localparam int DX_LSB      = DY_LSB + COORD_W;
  localparam int VC_LSB      = DX_LSB + COORD_W;
  localparam int KIND_LSB    = VC_LSB + VC_W;

  typedef logic [FLIT_W-1:0]  flit_t;
  typedef logic [KIND_W-1:0]  kind_t;
  typedef logic [PORT_W-1:0]  port_t;
  typedef logic [VC_W-1:0]    vc_t;
  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [COUNT_W-1:0] count_t;

  localparam kind_t KIND_HEAD   = 2'd0;
  localparam kind_t KIND_BODY   = 2'd1;
  localparam kind_t KIND_TAIL   = 2'd2;
  localparam kind_t KIND_SINGLE = 2'd3;

  localparam port_t PORT_NORTH = 3'd0;
  localparam port_t PORT_SOUTH = 3'd1;
  localparam port_t PORT_EAST  = 3'd2;
  localparam port_t PORT_WEST  = 3'd3;
  localparam port_t PORT_LOCAL = 3'd4;

  typedef enum logic [1:0] {VC_IDLE, VC_ROUTED, VC_ACTIVE} vc_state_e;

  function automatic kind_t flit_kind(input flit_t f);
    return f[KIND_LSB +: KIND_W];
  endfunction

  // Head or single flit opens a packet
  function automatic logic is_first(input flit_t f);
    return (flit_kind(f) == KIND_HEAD) || (flit_kind(f) == KIND_SINGLE);
  endfunction

  // Tail or single flit closes a packet
  function automatic logic is_last(input flit_t f);
    return (flit_kind(f) == KIND_TAIL) || (flit_kind(f) == KIND_SINGLE);
  endfunction

endpackage

/* common/sw_req_if.sv */
// Switch request and grant link between one input port and the allocator
`timescale 1ns/1ps

interface sw_req_if;
  import router_pkg::*;

  logic  req;
  port_t out_port;
  flit_t flit;
  // High for tail or single flit
  logic  last;
  logic  grant;

  // Input port presents a flit and waits for grant
  modport input_side (
    output req, out_port, flit, last,
    input  grant
  );

  modport switch_side (
    input  req, out_port, flit, last,
    output grant
  );

endinterface

/* design/input_unit/input_unit.sv */
// Input port with channel buffers, XY route computation, channel FSMs and channel selection
`timescale 1ns/1ps

module input_unit #(
  parameter router_pkg::coord_t ROUTER_X = 1,
  parameter router_pkg::coord_t ROUTER_Y = 2
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  input  router_pkg::flit_t                in_flit,
  output logic                             in_ready,
  sw_req_if.input_side                     sw,
  output logic [router_pkg::NUM_VCS-1:0]   vc_busy
);
  import router_pkg::*;

  vc_t                  in_vc;
  logic [NUM_VCS-1:0]   wr_en;
  logic [NUM_VCS-1:0]   rd_en;
  logic [NUM_VCS-1:0]   full;
  logic [NUM_VCS-1:0]   empty;
  flit_t                head_flit [NUM_VCS];
  vc_state_e            state [NUM_VCS];
  port_t                out_port_q [NUM_VCS];
  logic [NUM_VCS-1:0]   routed;
  logic [NUM_VCS-1:0]   sel_grant;
  logic                 any_active;
  vc_t                  act_vc;

  // X first, then Y, against this router's position
  function automatic port_t xy_route(input coord_t dx, input coord_t dy);
    port_t p;
    if (dx > ROUTER_X) p = PORT_EAST;
    else if (dx < ROUTER_X) p = PORT_WEST;
    else if (dy > ROUTER_Y) p = PORT_NORTH;
    else if (dy < ROUTER_Y) p = PORT_SOUTH;
    else p = PORT_LOCAL;
    return p;
  endfunction

  // ============================================================
  // Buffer write
  // ============================================================
  assign in_vc    = in_flit[VC_LSB +: VC_W];
  assign in_ready = !full[in_vc];

  always_comb begin
    for (int v = 0; v < NUM_VCS; v++) begin
      wr_en[v] = in_valid && (in_vc == vc_t'(v)) && !full[v];
      rd_en[v] = any_active && (act_vc == vc_t'(v)) && sw.req && sw.grant;
      routed[v]  = (state[v] == VC_ROUTED);
      vc_busy[v] = (state[v] != VC_IDLE);
    end
  end

  for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
    vc_buffer u_buf (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en[v]),
      .wr_data (in_flit),
      .rd_en   (rd_en[v]),
      .rd_data (head_flit[v]),
      .full    (full[v]),
      .empty   (empty[v])
    );

    // Channel FSM latches the route once per packet
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        state[v]      <= VC_IDLE;
        out_port_q[v] <= PORT_LOCAL;
      end else begin
        case (state[v])
          VC_IDLE: begin
            if (!empty[v] && is_first(head_flit[v])) begin
              state[v]      <= VC_ROUTED;
              out_port_q[v] <= xy_route(head_flit[v][DX_LSB +: COORD_W],
                                        head_flit[v][DY_LSB +: COORD_W]);
            end
          end
          VC_ROUTED: begin
            if (sel_grant[v]) state[v] <= VC_ACTIVE;
          end
          VC_ACTIVE: begin
            if (rd_en[v] && sw.last) state[v] <= VC_IDLE;
          end
          default: state[v] <= VC_IDLE;
        endcase
      end
    end
  end

  // ============================================================
  // Channel selection
  // ============================================================
  always_comb begin
    any_active = 1'b0;
    act_vc     = '0;
    for (int v = 0; v < NUM_VCS; v++) begin
      if (state[v] == VC_ACTIVE) begin
        any_active = 1'b1;
        act_vc     = vc_t'(v);
      end
    end
  end

  // A new channel is picked only once the port is free
  rr_arbiter #(.NUM_REQS(NUM_VCS)) u_vc_arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (routed & {NUM_VCS{!any_active}}),
    .advance (!any_active),
    .grant   (sel_grant)
  );

  assign sw.req      = any_active && !empty[act_vc];
  assign sw.flit     = head_flit[act_vc];
  assign sw.out_port = out_port_q[act_vc];
  assign sw.last     = is_last(head_flit[act_vc]);

endmodule

/* design/input_unit/vc_buffer.sv */
// Show-ahead flit FIFO for one virtual channel
`timescale 1ns/1ps

module vc_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en,
  input  router_pkg::flit_t wr_data,
  input  logic              rd_en,
  output router_pkg::flit_t rd_data,
  output logic              full,
  output logic              empty
);
  import router_pkg::*;

  localparam int PTR_W = $clog2(VC_DEPTH);
  localparam int CNT_W = $clog2(VC_DEPTH + 1);

  flit_t             mem [VC_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop;

  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  assign full    = (count == CNT_W'(VC_DEPTH));
  assign empty   = (count == '0);
  // Head flit is always on the output
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* design/router_top.sv */
// Mesh router top level with input units, switch allocator and output registers
`timescale 1ns/1ps

module router_top #(
  parameter router_pkg::coord_t ROUTER_X = 1,
  parameter router_pkg::coord_t ROUTER_Y = 2
) (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic [router_pkg::NUM_PORTS-1:0]                        in_valid,
  input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0]           in_flit,
  output logic [router_pkg::NUM_PORTS-1:0]                        in_ready,
  output logic [router_pkg::NUM_PORTS-1:0]                        out_valid,
  output router_pkg::flit_t [router_pkg::NUM_PORTS-1:0]           out_flit,
  input  logic [router_pkg::NUM_PORTS-1:0]                        out_ready,
  output logic [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_VCS-1:0] vc_busy,
  output router_pkg::count_t                                      packets_routed
);
  import router_pkg::*;

  logic  [NUM_PORTS-1:0] take;
  logic  [NUM_PORTS-1:0] load;
  flit_t [NUM_PORTS-1:0] load_flit;

  // One request link per input port, ordered N, S, E, W, local
  sw_req_if sw_links [NUM_PORTS] ();

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    input_unit #(
      .ROUTER_X (ROUTER_X),
      .ROUTER_Y (ROUTER_Y)
    ) u_in (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid[p]),
      .in_flit  (in_flit[p]),
      .in_ready (in_ready[p]),
      .sw       (sw_links[p]),
      .vc_busy  (vc_busy[p])
    );
  end

  switch_allocator u_alloc (
    .clk       (clk),
    .rst_n     (rst_n),
    .ins       (sw_links),
    .take      (take),
    .load      (load),
    .load_flit (load_flit)
  );

  output_stage u_out (
    .clk            (clk),
    .rst_n          (rst_n),
    .load           (load),
    .load_flit      (load_flit),
    .take           (take),
    .out_valid      (out_valid),
    .out_flit       (out_flit),
    .out_ready      (out_ready),
    .packets_routed (packets_routed)
  );

endmodule

/* design/switch/output_stage.sv */
// One-flit output registers with valid/ready back-pressure and packet counter
`timescale 1ns/1ps

module output_stage (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [router_pkg::NUM_PORTS-1:0]              load,
  input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] load_flit,
  output logic [router_pkg::NUM_PORTS-1:0]              take,
  output logic [router_pkg::NUM_PORTS-1:0]              out_valid,
  output router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] out_flit,
  input  logic [router_pkg::NUM_PORTS-1:0]              out_ready,
  output router_pkg::count_t                            packets_routed
);
  import router_pkg::*;

  logic [$clog2(NUM_PORTS+1)-1:0] leaving;

  // Register can accept when empty or draining this cycle
  assign take = ~out_valid | out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (take[p]) out_valid[p] <= load[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (take[p] && load[p]) out_flit[p] <= load_flit[p];
    end
  end

  // Packets closing on any port this cycle
  always_comb begin
    leaving = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (out_valid[p] && out_ready[p] && is_last(out_flit[p])) leaving = leaving + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      packets_routed <= '0;
    end else begin
      packets_routed <= packets_routed + count_t'(leaving);
    end
  end

endmodule

/* design/switch/rr_arbiter.sv */
// Round-robin arbiter with rotating priority pointer
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int NUM_REQS = 5
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_REQS-1:0] req,
  input  logic                advance,
  output logic [NUM_REQS-1:0] grant
);

  localparam int PTR_W = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;

  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] win_idx;
  logic             found;

  // First requester at or after the pointer wins
  always_comb begin
    grant   = '0;
    win_idx = '0;
    found   = 1'b0;
    for (int i = 0; i < NUM_REQS; i++) begin
      if (!found && req[(int'(ptr) + i) % NUM_REQS]) begin
        found   = 1'b1;
        grant[(int'(ptr) + i) % NUM_REQS] = 1'b1;
        win_idx = PTR_W'((int'(ptr) + i) % NUM_REQS);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (advance && found) begin
      if (win_idx == PTR_W'(NUM_REQS - 1)) ptr <= '0;
      else ptr <= win_idx + 1'b1;
    end
  end

endmodule

/* design/switch/switch_allocator.sv */
// Per-output switch arbitration with wormhole lock and crossbar multiplexing
`timescale 1ns/1ps

module switch_allocator (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  sw_req_if.switch_side                                          ins [router_pkg::NUM_PORTS],
  input  logic [router_pkg::NUM_PORTS-1:0]                       take,
  output logic [router_pkg::NUM_PORTS-1:0]                       load,
  output router_pkg::flit_t [router_pkg::NUM_PORTS-1:0]          load_flit
);
  import router_pkg::*;

  logic  [NUM_PORTS-1:0]                in_req;
  logic  [NUM_PORTS-1:0]                in_last;
  logic  [NUM_PORTS-1:0]                in_grant;
  port_t [NUM_PORTS-1:0]                in_port;
  flit_t [NUM_PORTS-1:0]                in_flit;
  logic  [NUM_PORTS-1:0][NUM_PORTS-1:0] cand;
  logic  [NUM_PORTS-1:0][NUM_PORTS-1:0] arb_req;
  logic  [NUM_PORTS-1:0][NUM_PORTS-1:0] out_grant;
  logic  [NUM_PORTS-1:0]                locked;
  logic  [NUM_PORTS-1:0]                load_last;
  port_t [NUM_PORTS-1:0]                lock_in;
  port_t [NUM_PORTS-1:0]                grant_idx;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
    assign in_req[i]    = ins[i].req;
    assign in_port[i]   = ins[i].out_port;
    assign in_flit[i]   = ins[i].flit;
    assign in_last[i]   = ins[i].last;
    assign ins[i].grant = in_grant[i];
  end

  // ============================================================
  // Request gathering where a locked output sees only its owner
  // ============================================================
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        cand[o][i] = in_req[i] && (in_port[i] == port_t'(o)) &&
                     (!locked[o] || (lock_in[o] == port_t'(i)));
      end
      arb_req[o] = take[o] ? cand[o] : '0;
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
    // Pointer moves only when a new packet wins
    rr_arbiter #(.NUM_REQS(NUM_PORTS)) u_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (arb_req[o]),
      .advance (!locked[o]),
      .grant   (out_grant[o])
    );
  end

  // ============================================================
  // Crossbar
  // ============================================================
  always_comb begin
    in_grant = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      load[o]      = |out_grant[o];
      load_flit[o] = '0;
      load_last[o] = 1'b0;
      grant_idx[o] = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (out_grant[o][i]) begin
          load_flit[o] = in_flit[i];
          load_last[o] = in_last[i];
          grant_idx[o] = port_t'(i);
          in_grant[i]  = 1'b1;
        end
      end
    end
  end

  // Lock holds the output until the tail has passed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked  <= '0;
      lock_in <= '0;
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (load[o]) begin
          locked[o]  <= !load_last[o];
          lock_in[o] <= grant_idx[o];
        end
      end
    end
  end

endmodule

/* list.f */
common/router_pkg.sv
common/sw_req_if.sv
design/input_unit/vc_buffer.sv
design/switch/rr_arbiter.sv
design/input_unit/input_unit.sv
design/switch/switch_allocator.sv
design/switch/output_stage.sv
design/router_top.sv
bench/router_props.sv
bench/router_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the router testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f list.f --top-module router_tb \
  -Mdir obj_dir -o router_sim && ./obj_dir/router_sim || exit 1
